/* hdl/l1_cache_pkg.sv */
package l1_cache_pkg;

    // Core and memory bus geometry
    localparam int addr_w = 32;
    localparam int data_w = 64;
    localparam int strb_w = data_w / 8;

    // Line layout is 4 double words of 8 bytes each
    localparam int beat_bits = 2;
    localparam int byte_bits = 3;

    // Flag positions in a metadata word
    // Tag occupies the bits above the flags
    localparam int meta_valid = 0;
    localparam int meta_dirty = 1;
    localparam int meta_lru = 2;
    localparam int meta_flag_w = 3;

    // Controller states
    typedef enum logic [2:0] {
        st_invalidate,
        st_prepare,
        st_ready,
        st_flush,
        st_flush_ack,
        st_load,
        st_way_wb,
        st_retry
    } cache_state_e;

    // Source of the value written into the way RAMs
    typedef enum logic [1:0] {
        wb_core,
        wb_mem,
        wb_clear
    } wb_src_e;

endpackage

/* hdl/lookup_if.sv */
`timescale 1ns/1ps

interface lookup_if;
    import l1_cache_pkg::*;

    // Per-way tag match with valid
    logic [1:0] hit;
    // Stage-2 request present but no way matched
    logic miss;
    // Way chosen for replacement and its dirty state
    logic victim;
    logic victim_dirty;
    // Line address of the victim for the write burst
    logic [addr_w-1:0] flush_addr;

    // Write value select and forced write enables outside of ready
    wb_src_e wb_src;
    logic [1:0] meta_we_force;
    logic [1:0] data_we_force;
    // Pipeline may advance
    logic int_ready;

    modport lookup(
        output hit, miss, victim, victim_dirty, flush_addr,
        input wb_src
    );

    modport ctrl(
        input miss, victim, victim_dirty, flush_addr,
        output wb_src, meta_we_force, data_we_force, int_ready
    );

endinterface

/* hdl/cache_ram.sv */
`timescale 1ns/1ps

module cache_ram #(
    parameter int sets = 16,
    parameter int width = 64,
    localparam int aw = $clog2(sets)
) (
    input logic clk,
    input logic [aw-1:0] raddr,
    output logic [width-1:0] rdata,
    input logic [aw-1:0] waddr,
    input logic we,
    input logic [width-1:0] wdata
);

    logic [width-1:0] mem [sets];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read
    // Same-address write is forwarded so a hit sees its own update
    always_ff @(posedge clk) begin
        if (we && (waddr == raddr)) begin
            rdata <= wdata;
        end else begin
            rdata <= mem[raddr];
        end
    end

endmodule

/* hdl/cache_lookup.sv */
`timescale 1ns/1ps

module cache_lookup #(
    parameter int sets = 16,
    localparam int set_bits = $clog2(sets),
    localparam int tag_w = l1_cache_pkg::addr_w - l1_cache_pkg::byte_bits
        - l1_cache_pkg::beat_bits - set_bits,
    localparam int meta_w = tag_w + l1_cache_pkg::meta_flag_w
) (
    lookup_if.lookup lk,
    input logic [l1_cache_pkg::addr_w-1:0] req_addr,
    input logic req_wen,
    input logic [l1_cache_pkg::data_w-1:0] req_wdata,
    input logic [l1_cache_pkg::strb_w-1:0] req_wmask,
    input logic req_valid,
    input logic [meta_w-1:0] meta_rd [2],
    input logic [l1_cache_pkg::data_w-1:0] data_rd [2],
    input logic [l1_cache_pkg::data_w-1:0] mem_resp_rdata,
    output logic [meta_w-1:0] meta_wr [2],
    output logic [l1_cache_pkg::data_w-1:0] data_wr [2],
    output logic [l1_cache_pkg::data_w-1:0] resp_rdata,
    output logic resp_valid
);
    import l1_cache_pkg::*;

    localparam int line_lsb = beat_bits + byte_bits;

    logic [tag_w-1:0] req_tag;
    logic [set_bits-1:0] req_set;
    logic [1:0] hit;
    logic [1:0] new_lru;
    logic victim;

    assign req_tag = req_addr[addr_w-1 -: tag_w];
    assign req_set = req_addr[line_lsb +: set_bits];

    // LRU pair
    // Equal bits mean way 0 is newer
    assign victim = (meta_rd[0][meta_lru] == meta_rd[1][meta_lru]);
    // Way 0 copies way 1 to become newest, way 1 inverts way 0
    assign new_lru[0] = meta_rd[1][meta_lru];
    assign new_lru[1] = !meta_rd[0][meta_lru];

    for (genvar w = 0; w < 2; w++) begin : g_way
        logic [meta_w-1:0] meta_core;
        logic [meta_w-1:0] meta_mem;
        logic [data_w-1:0] merged;

        assign hit[w] = meta_rd[w][meta_valid] && (meta_rd[w][meta_w-1 -: tag_w] == req_tag);

        always_comb begin
            // Core access keeps the tag and may set dirty
            meta_core = meta_rd[w];
            meta_core[meta_valid] = 1'b1;
            meta_core[meta_dirty] = req_wen || meta_rd[w][meta_dirty];
            meta_core[meta_lru] = new_lru[w];
            // Reload installs the request tag as a clean line
            meta_mem = '0;
            meta_mem[meta_w-1 -: tag_w] = req_tag;
            meta_mem[meta_valid] = 1'b1;
            meta_mem[meta_lru] = new_lru[w];
        end

        // Byte merge of write data over the stored double word
        for (genvar b = 0; b < strb_w; b++) begin : g_byte
            assign merged[b*8 +: 8] = req_wmask[b] ? req_wdata[b*8 +: 8] : data_rd[w][b*8 +: 8];
        end

        always_comb begin
            case (lk.wb_src)
                wb_core: begin
                    meta_wr[w] = meta_core;
                    data_wr[w] = merged;
                end
                wb_mem: begin
                    meta_wr[w] = meta_mem;
                    data_wr[w] = mem_resp_rdata;
                end
                default: begin
                    meta_wr[w] = '0;
                    data_wr[w] = '0;
                end
            endcase
        end
    end

    assign lk.hit = hit;
    assign lk.miss = req_valid && !(|hit);
    assign lk.victim = victim;
    assign lk.victim_dirty = meta_rd[victim][meta_valid] && meta_rd[victim][meta_dirty];
    // Victim line base address
    assign lk.flush_addr = {meta_rd[victim][meta_w-1 -: tag_w], req_set, {line_lsb{1'b0}}};

    // Hit data path
    assign resp_rdata = hit[1] ? data_rd[1] : data_rd[0];
    assign resp_valid = req_valid && (|hit);

endmodule

/* hdl/cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl #(
    parameter int sets = 16,
    localparam int set_bits = $clog2(sets)
) (
    input logic clk,
    input logic rst,
    lookup_if.ctrl lk,
    input logic [l1_cache_pkg::addr_w-1:0] load_addr,
    input logic [l1_cache_pkg::beat_bits-1:0] req_beat,
    input logic mem_req_ready,
    input logic mem_resp_valid,
    output logic [l1_cache_pkg::addr_w-1:0] mem_req_addr,
    output logic mem_req_wen,
    output logic mem_req_valid,
    output logic mem_resp_ready,
    output logic invalidate_en,
    output logic [set_bits-1:0] inv_set,
    output logic reload_en,
    output logic [l1_cache_pkg::beat_bits-1:0] beat
);
    import l1_cache_pkg::*;

    cache_state_e state;
    logic [beat_bits-1:0] cnt;
    logic [beat_bits-1:0] cnt_next;
    logic ready_w;
    logic req_fire;
    logic resp_fire;

    assign req_fire = mem_req_valid && mem_req_ready;
    assign resp_fire = mem_resp_valid && mem_resp_ready;

    // Hits flow only in ready
    assign ready_w = (state == st_ready) && !lk.miss;
    assign lk.int_ready = ready_w;
    assign reload_en = !ready_w;
    assign invalidate_en = (state == st_invalidate);

    // Beat counter next value
    always_comb begin
        cnt_next = cnt;
        case (state)
            st_ready: begin
                if (lk.miss) begin
                    cnt_next = '0;
                end
            end
            st_flush: begin
                if (req_fire) begin
                    cnt_next = cnt + 1'b1;
                end
            end
            st_flush_ack: begin
                if (resp_fire) begin
                    cnt_next = '0;
                end
            end
            st_load: begin
                if (resp_fire) begin
                    // After the last beat point the data read at the retried request
                    cnt_next = (&cnt) ? req_beat : cnt + 1'b1;
                end
            end
            default: begin
                cnt_next = cnt;
            end
        endcase
    end

    // Load writes the current beat
    // Other states read one beat ahead to cover the RAM latency
    assign beat = (state == st_load) ? cnt : cnt_next;

    // Forced writes and write value select
    always_comb begin
        lk.meta_we_force = 2'b00;
        lk.data_we_force = 2'b00;
        lk.wb_src = wb_core;
        case (state)
            st_invalidate: begin
                lk.meta_we_force = 2'b11;
                lk.wb_src = wb_clear;
            end
            st_load: begin
                lk.wb_src = wb_mem;
                lk.data_we_force[lk.victim] = resp_fire;
            end
            st_way_wb: begin
                lk.wb_src = wb_mem;
                lk.meta_we_force[lk.victim] = 1'b1;
            end
            default: begin
                lk.wb_src = wb_core;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_invalidate;
            inv_set <= '0;
            cnt <= '0;
            mem_req_valid <= 1'b0;
            mem_resp_ready <= 1'b0;
        end else begin
            cnt <= cnt_next;
            case (state)
                st_invalidate: begin
                    inv_set <= inv_set + 1'b1;
                    if (inv_set == set_bits'(sets - 1)) begin
                        state <= st_prepare;
                    end
                end
                st_prepare: begin
                    state <= st_ready;
                end
                st_ready: begin
                    if (lk.miss) begin
                        mem_req_valid <= 1'b1;
                        // Dirty victim goes out before the reload
                        if (lk.victim_dirty) begin
                            state <= st_flush;
                        end else begin
                            mem_resp_ready <= 1'b1;
                            state <= st_load;
                        end
                    end
                end
                st_flush: begin
                    if (req_fire && (&cnt)) begin
                        mem_req_valid <= 1'b0;
                        mem_resp_ready <= 1'b1;
                        state <= st_flush_ack;
                    end
                end
                st_flush_ack: begin
                    // Write acknowledged so issue the read
                    if (resp_fire) begin
                        mem_req_valid <= 1'b1;
                        state <= st_load;
                    end
                end
                st_load: begin
                    if (req_fire) begin
                        mem_req_valid <= 1'b0;
                    end
                    if (resp_fire && (&cnt)) begin
                        mem_resp_ready <= 1'b0;
                        state <= st_way_wb;
                    end
                end
                st_way_wb: begin
                    state <= st_retry;
                end
                default: begin
                    // Retry waits for the new metadata to be read back
                    state <= st_ready;
                end
            endcase
        end
    end

    // Memory request address and direction
    always_ff @(posedge clk) begin
        if ((state == st_ready) && lk.miss) begin
            mem_req_addr <= lk.victim_dirty ? lk.flush_addr : load_addr;
            mem_req_wen <= lk.victim_dirty;
        end else if ((state == st_flush_ack) && resp_fire) begin
            mem_req_addr <= load_addr;
            mem_req_wen <= 1'b0;
        end
    end

endmodule

/* hdl/l1_cache.sv */
`timescale 1ns/1ps

module l1_cache #(
    parameter int sets = 16
) (
    input logic clk,
    input logic rst,
    input logic [l1_cache_pkg::addr_w-1:0] core_req_addr,
    input logic core_req_wen,
    input logic [l1_cache_pkg::data_w-1:0] core_req_wdata,
    input logic [l1_cache_pkg::strb_w-1:0] core_req_wmask,
    input logic core_req_valid,
    output logic core_req_ready,
    output logic [l1_cache_pkg::data_w-1:0] core_resp_rdata,
    output logic core_resp_valid,
    output logic [l1_cache_pkg::addr_w-1:0] mem_req_addr,
    output logic mem_req_wen,
    output logic [l1_cache_pkg::data_w-1:0] mem_req_wdata,
    output logic mem_req_valid,
    input logic mem_req_ready,
    input logic [l1_cache_pkg::data_w-1:0] mem_resp_rdata,
    input logic mem_resp_valid,
    output logic mem_resp_ready
);
    import l1_cache_pkg::*;

    localparam int set_bits = $clog2(sets);
    localparam int line_lsb = beat_bits + byte_bits;
    localparam int tag_w = addr_w - line_lsb - set_bits;
    localparam int meta_w = tag_w + meta_flag_w;

    // Stage-2 request
    logic [addr_w-1:0] p2_addr;
    logic p2_wen;
    logic [data_w-1:0] p2_wdata;
    logic [strb_w-1:0] p2_wmask;
    logic p2_valid;

    logic invalidate_en;
    logic reload_en;
    logic [set_bits-1:0] inv_set;
    logic [beat_bits-1:0] beat;
    logic [set_bits-1:0] core_set;
    logic [set_bits-1:0] p2_set;
    logic [set_bits-1:0] meta_raddr;
    logic [set_bits-1:0] meta_waddr;
    logic [set_bits+beat_bits-1:0] data_raddr;
    logic [set_bits+beat_bits-1:0] data_waddr;
    logic [meta_w-1:0] meta_rd [2];
    logic [meta_w-1:0] meta_wr [2];
    logic [data_w-1:0] data_rd [2];
    logic [data_w-1:0] data_wr [2];
    logic [1:0] meta_we;
    logic [1:0] data_we;
    logic [addr_w-1:0] load_addr;
    logic resp_valid;

    lookup_if lk();

    always_ff @(posedge clk) begin
        if (rst) begin
            p2_valid <= 1'b0;
        end else if (lk.int_ready) begin
            p2_valid <= core_req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (lk.int_ready) begin
            p2_addr <= core_req_addr;
            p2_wen <= core_req_wen;
            p2_wdata <= core_req_wdata;
            p2_wmask <= core_req_wmask;
        end
    end

    assign core_set = core_req_addr[line_lsb +: set_bits];
    assign p2_set = p2_addr[line_lsb +: set_bits];
    assign load_addr = {p2_addr[addr_w-1:line_lsb], {line_lsb{1'b0}}};

    // Hold the missed set while stalled
    assign meta_raddr = lk.int_ready ? core_set : p2_set;
    assign meta_waddr = invalidate_en ? inv_set : p2_set;
    // Beat counter drives the data RAMs during a miss
    assign data_raddr = reload_en ? {p2_set, beat} : core_req_addr[byte_bits +: set_bits + beat_bits];
    assign data_waddr = reload_en ? {p2_set, beat} : p2_addr[byte_bits +: set_bits + beat_bits];

    for (genvar w = 0; w < 2; w++) begin : g_way
        assign meta_we[w] = lk.int_ready ? (lk.hit[w] && p2_valid) : lk.meta_we_force[w];
        assign data_we[w] = lk.int_ready ? (lk.hit[w] && p2_valid && p2_wen) : lk.data_we_force[w];

        cache_ram #(.sets(sets), .width(meta_w)) meta_ram_i (
            .clk(clk),
            .raddr(meta_raddr),
            .rdata(meta_rd[w]),
            .waddr(meta_waddr),
            .we(meta_we[w]),
            .wdata(meta_wr[w])
        );

        cache_ram #(.sets(sets << beat_bits), .width(data_w)) data_ram_i (
            .clk(clk),
            .raddr(data_raddr),
            .rdata(data_rd[w]),
            .waddr(data_waddr),
            .we(data_we[w]),
            .wdata(data_wr[w])
        );
    end

    cache_lookup #(.sets(sets)) lookup_i (
        .lk(lk),
        .req_addr(p2_addr),
        .req_wen(p2_wen),
        .req_wdata(p2_wdata),
        .req_wmask(p2_wmask),
        .req_valid(p2_valid),
        .meta_rd(meta_rd),
        .data_rd(data_rd),
        .mem_resp_rdata(mem_resp_rdata),
        .meta_wr(meta_wr),
        .data_wr(data_wr),
        .resp_rdata(core_resp_rdata),
        .resp_valid(resp_valid)
    );

    cache_ctrl #(.sets(sets)) ctrl_i (
        .clk(clk),
        .rst(rst),
        .lk(lk),
        .load_addr(load_addr),
        .req_beat(p2_addr[byte_bits +: beat_bits]),
        .mem_req_ready(mem_req_ready),
        .mem_resp_valid(mem_resp_valid),
        .mem_req_addr(mem_req_addr),
        .mem_req_wen(mem_req_wen),
        .mem_req_valid(mem_req_valid),
        .mem_resp_ready(mem_resp_ready),
        .invalidate_en(invalidate_en),
        .inv_set(inv_set),
        .reload_en(reload_en),
        .beat(beat)
    );

    assign core_req_ready = lk.int_ready;
    assign core_resp_valid = lk.int_ready && resp_valid;
    // Write burst streams the victim way
    assign mem_req_wdata = data_rd[lk.victim];

endmodule

/* verification/l1_cache_props.sv */
`timescale 1ns/1ps

module l1_cache_props (
    input logic clk,
    input logic rst,
    input logic [l1_cache_pkg::addr_w-1:0] mem_req_addr,
    input logic mem_req_wen,
    input logic mem_req_valid,
    input logic mem_req_ready,
    input logic mem_resp_ready,
    input logic core_req_valid,
    input logic core_req_ready,
    input logic core_resp_valid
);

    // Request fields hold until the memory takes them
    req_hold_a: assert property (
        @(posedge clk) disable iff (rst)
        (mem_req_valid && !mem_req_ready)
            |=> (mem_req_valid && $stable(mem_req_addr) && $stable(mem_req_wen))
    ) else $error("memory request changed before it was accepted");

    // A response only leaves while the pipeline advances
    // Hit answers the cycle after acceptance, a miss answers as ready comes back
    resp_ready_a: assert property (
        @(posedge clk) disable iff (rst)
        core_resp_valid |-> (core_req_ready
            && ($past(core_req_valid && core_req_ready) || $rose(core_req_ready)))
    ) else $error("core_resp_valid outside of its response cycle");

    // Write acknowledge is only awaited after the burst
    burst_ack_a: assert property (
        @(posedge clk) disable iff (rst)
        (mem_req_valid && mem_req_wen) |-> !mem_resp_ready
    ) else $error("mem_resp_ready raised during a write burst");

endmodule

bind l1_cache l1_cache_props props_i (
    .clk(clk),
    .rst(rst),
    .mem_req_addr(mem_req_addr),
    .mem_req_wen(mem_req_wen),
    .mem_req_valid(mem_req_valid),
    .mem_req_ready(mem_req_ready),
    .mem_resp_ready(mem_resp_ready),
    .core_req_valid(core_req_valid),
    .core_req_ready(core_req_ready),
    .core_resp_valid(core_resp_valid)
);

/* verification/l1_cache_tb.sv */
`timescale 1ns/1ps

module l1_cache_tb;
    import l1_cache_pkg::*;

    localparam int sets = 16;
    localparam int n_tests = 16;
    localparam int mem_words = 4096;
    localparam logic [addr_w-1:0] no_wb = 32'hffff_ffff;

    // One stimulus row with its expected cache behavior
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic wen;
        logic [data_w-1:0] wdata;
        logic [strb_w-1:0] wmask;
        logic hit;
        logic [addr_w-1:0] wb;
    } entry_t;

    logic clk = 1'b0;
    logic rst;
    logic [addr_w-1:0] core_req_addr;
    logic core_req_wen;
    logic [data_w-1:0] core_req_wdata;
    logic [strb_w-1:0] core_req_wmask;
    logic core_req_valid;
    logic core_req_ready;
    logic [data_w-1:0] core_resp_rdata;
    logic core_resp_valid;
    logic [addr_w-1:0] mem_req_addr;
    logic mem_req_wen;
    logic [data_w-1:0] mem_req_wdata;
    logic mem_req_valid;
    logic mem_req_ready;
    logic [data_w-1:0] mem_resp_rdata;
    logic mem_resp_valid;
    logic mem_resp_ready;

    // Expected contents and the memory model's own array
    logic [data_w-1:0] shadow [mem_words];
    logic [data_w-1:0] mem_model [mem_words];
    // Memory transfers seen, wen above the line address
    logic [addr_w:0] mem_log [64];
    int log_count;
    int errors;
    int checks;

    l1_cache #(.sets(sets)) dut_i (
        .clk(clk),
        .rst(rst),
        .core_req_addr(core_req_addr),
        .core_req_wen(core_req_wen),
        .core_req_wdata(core_req_wdata),
        .core_req_wmask(core_req_wmask),
        .core_req_valid(core_req_valid),
        .core_req_ready(core_req_ready),
        .core_resp_rdata(core_resp_rdata),
        .core_resp_valid(core_resp_valid),
        .mem_req_addr(mem_req_addr),
        .mem_req_wen(mem_req_wen),
        .mem_req_wdata(mem_req_wdata),
        .mem_req_valid(mem_req_valid),
        .mem_req_ready(mem_req_ready),
        .mem_resp_rdata(mem_resp_rdata),
        .mem_resp_valid(mem_resp_valid),
        .mem_resp_ready(mem_resp_ready)
    );

    always #4 clk = ~clk;

    // Power-up memory value from the full byte address
    function automatic logic [data_w-1:0] fill_value(input logic [addr_w-1:0] addr);
        return {addr * 32'h9e37_79b9, addr ^ 32'hc3a5_0f1e};
    endfunction

    function automatic logic [11:0] word_idx(input logic [addr_w-1:0] addr);
        return addr[14:3];
    endfunction

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Lines 0x1040, 0x1240 and 0x1440 all map to set 2
    function automatic entry_t table_entry(input int n);
        case (n)
            0: return '{32'h0000_1040, 1'b0, 64'h0, 8'h00, 1'b0, no_wb};
            1: return '{32'h0000_1040, 1'b0, 64'h0, 8'h00, 1'b1, no_wb};
            2: return '{32'h0000_1048, 1'b1, 64'h1122_3344_5566_7788, 8'h0f, 1'b1, no_wb};
            3: return '{32'h0000_1048, 1'b0, 64'h0, 8'h00, 1'b1, no_wb};
            4: return '{32'h0000_1248, 1'b0, 64'h0, 8'h00, 1'b0, no_wb};
            5: return '{32'h0000_1250, 1'b1, 64'hdead_beef_0bad_f00d, 8'hf0, 1'b1, no_wb};
            6: return '{32'h0000_1040, 1'b0, 64'h0, 8'h00, 1'b1, no_wb};
            // C evicts the dirty B, A stays
            7: return '{32'h0000_1440, 1'b0, 64'h0, 8'h00, 1'b0, 32'h0000_1240};
            8: return '{32'h0000_1250, 1'b0, 64'h0, 8'h00, 1'b0, 32'h0000_1040};
            9: return '{32'h0000_1458, 1'b0, 64'h0, 8'h00, 1'b1, no_wb};
            10: return '{32'h0000_1048, 1'b0, 64'h0, 8'h00, 1'b0, no_wb};
            11: return '{32'h0000_00a8, 1'b1, 64'h0123_4567_89ab_cdef, 8'hff, 1'b0, no_wb};
            12: return '{32'h0000_00a8, 1'b0, 64'h0, 8'h00, 1'b1, no_wb};
            13: return '{32'h0000_00b0, 1'b0, 64'h0, 8'h00, 1'b1, no_wb};
            14: return '{32'h0000_7fe0, 1'b0, 64'h0, 8'h00, 1'b0, no_wb};
            default: return '{32'h0000_7ff8, 1'b0, 64'h0, 8'h00, 1'b1, no_wb};
        endcase
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic run_entry(input int n);
        entry_t e;
        int lat;
        int err0;
        int log0;
        int n_ev;
        logic [11:0] idx;
        logic [11:0] wb_idx;
        e = table_entry(n);
        err0 = errors;
        log0 = log_count;
        idx = word_idx(e.addr);
        wb_idx = word_idx(e.wb);
        core_req_addr = e.addr;
        core_req_wen = e.wen;
        core_req_wdata = e.wdata;
        core_req_wmask = e.wmask;
        core_req_valid = 1'b1;
        // Taken at the next rising edge with ready high
        while (!core_req_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        core_req_valid = 1'b0;
        lat = 1;
        while (!core_resp_valid) begin
            @(negedge clk);
            lat++;
        end
        check_value("core_req_ready", 64'(core_req_ready), 64'd1);
        if (e.hit) begin
            check_value("hit latency", 64'(lat), 64'd1);
            check_value("memory requests", 64'(log_count - log0), 64'd0);
        end else begin
            n_ev = (e.wb == no_wb) ? 1 : 2;
            check_value("memory requests", 64'(log_count - log0), 64'(n_ev));
            if (log_count - log0 == n_ev) begin
                // Write burst of the victim comes first
                if (n_ev == 2) begin
                    check_value("flush mem_req_wen", 64'(mem_log[6'(log0)][addr_w]), 64'd1);
                    check_value("flush mem_req_addr", 64'(mem_log[6'(log0)][addr_w-1:0]),
                                64'(e.wb));
                    for (int k = 0; k < 4; k++) begin
                        check_value("mem_req_wdata", mem_model[wb_idx + 12'(k)],
                                    shadow[wb_idx + 12'(k)]);
                    end
                end
                check_value("load mem_req_wen", 64'(mem_log[6'(log0 + n_ev - 1)][addr_w]), 64'd0);
                check_value("load mem_req_addr", 64'(mem_log[6'(log0 + n_ev - 1)][addr_w-1:0]),
                            64'({e.addr[addr_w-1:5], 5'b0}));
            end
        end
        if (e.wen) begin
            for (int b = 0; b < strb_w; b++) begin
                if (e.wmask[b]) begin
                    shadow[idx][b*8 +: 8] = e.wdata[b*8 +: 8];
                end
            end
        end else begin
            check_value("core_resp_rdata", core_resp_rdata, shadow[idx]);
        end
        $display("test %0d %s %h latency %0d: %s", n, e.wen ? "write" : "read", e.addr, lat,
                 (errors == err0) ? "ok" : "FAIL");
    endtask

    // Behavioral memory with random handshake gaps
    initial begin : memory_model
        logic [31:0] lfsr;
        int rd_left;
        int wr_beats;
        logic ack_due;
        logic [11:0] rd_idx;
        lfsr = 32'hbe79_bc7d;
        rd_left = 0;
        wr_beats = 0;
        ack_due = 1'b0;
        rd_idx = '0;
        log_count = 0;
        mem_req_ready = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_rdata = '0;
        for (int i = 0; i < mem_words; i++) begin
            mem_model[12'(i)] = fill_value(32'(i * 8));
        end
        forever begin
            @(negedge clk);
            lfsr = lfsr_step(lfsr);
            mem_req_ready = lfsr[0] && !rst;
            lfsr = lfsr_step(lfsr);
            mem_resp_valid = 1'b0;
            if (rd_left > 0 && lfsr[0]) begin
                mem_resp_valid = 1'b1;
                mem_resp_rdata = mem_model[rd_idx];
                if (mem_resp_ready) begin
                    rd_idx = rd_idx + 12'd1;
                    rd_left--;
                end
            end else if (ack_due && mem_resp_ready && lfsr[0]) begin
                mem_resp_valid = 1'b1;
                ack_due = 1'b0;
            end
            // Handshake completes at the coming rising edge
            if (mem_req_valid && mem_req_ready) begin
                if (mem_req_wen) begin
                    if (wr_beats == 0) begin
                        mem_log[6'(log_count)] = {1'b1, mem_req_addr};
                        log_count++;
                    end
                    mem_model[word_idx(mem_req_addr) + 12'(wr_beats)] = mem_req_wdata;
                    wr_beats++;
                    if (wr_beats == 4) begin
                        wr_beats = 0;
                        ack_due = 1'b1;
                    end
                end else begin
                    mem_log[6'(log_count)] = {1'b0, mem_req_addr};
                    log_count++;
                    rd_idx = word_idx(mem_req_addr);
                    rd_left = 4;
                end
            end
        end
    end

    initial begin : stimulus
        int low;
        logic out_seen;
        rst = 1'b1;
        core_req_addr = '0;
        core_req_wen = 1'b0;
        core_req_wdata = '0;
        core_req_wmask = '0;
        core_req_valid = 1'b0;
        errors = 0;
        checks = 0;
        for (int i = 0; i < mem_words; i++) begin
            shadow[12'(i)] = fill_value(32'(i * 8));
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;
        // Invalidate walk plus the prepare cycle
        low = 0;
        out_seen = 1'b0;
        while (!core_req_ready && low < 4 * sets) begin
            out_seen = out_seen | mem_req_valid | mem_resp_ready | core_resp_valid;
            low++;
            @(negedge clk);
        end
        check_value("core_req_ready low cycles", 64'(low), 64'(sets + 1));
        check_value("mem_req_valid during invalidate", 64'(out_seen), 64'd0);
        $display("reset walk %0d cycles: %s", low, (errors == 0) ? "ok" : "FAIL");
        for (int n = 0; n < n_tests; n++) begin
            run_entry(n);
        end
        $display("%0d tests, %0d checks, %0d errors", n_tests + 1, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (n_tests * 200) @(posedge clk);
        $display("Timeout, the cache did not finish the table within %0d cycles", n_tests * 200);
        $display("Test failed");
        $finish;
    end

endmodule

/* build.f */
hdl/l1_cache_pkg.sv
hdl/lookup_if.sv
hdl/cache_ram.sv
hdl/cache_lookup.sv
hdl/cache_ctrl.sv
hdl/l1_cache.sv
verification/l1_cache_props.sv
verification/l1_cache_tb.sv

/* Makefile */
TOP = l1_cache_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir
